// ==== src/rv_exec_pkg.sv ====
package rv_exec_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int XLEN = 32;          // data and pc width
	localparam int REG_ADDR_W = 5;     // register number width
	localparam int PC_STEP = 4;        // sequential pc increment

	// major opcodes kept by this core
	typedef enum logic [6:0] {
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_BRANCH   = 7'b1100011,
		OPC_MISC_MEM = 7'b0001111     // fence
	} opcode_e;

	// operations carried out by the execute unit
	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B,                   // lui, auipc
		ALU_BEQ,
		ALU_BNE,
		ALU_BLT,
		ALU_BGE,
		ALU_BLTU,
		ALU_BGEU,
		ALU_JAL,
		ALU_JALR,
		ALU_NONE                      // fence, illegal
	} alu_op_e;

	// ----------------------------------------
	// funct3 / funct7 codes
	// ----------------------------------------
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;     // srl / sra
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_FENCE = 3'b000;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra

endpackage

// ==== src/rv_exec_ifs.sv ====
// decoded instruction, decoder to execute unit
interface decode_if;
	import rv_exec_pkg::*;

	logic valid;
	alu_op_e alu_op;
	logic use_imm;                    // operand b from imm
	logic [XLEN-1:0] imm;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0] pc;
	logic err;

	modport producer (
		output valid, alu_op, use_imm, imm, rd, pc, err
	);
	modport consumer (
		input valid, alu_op, use_imm, imm, rd, pc, err
	);
endinterface

// register file access, two reads and one write
interface regfile_if;
	import rv_exec_pkg::*;

	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic we;
	logic [REG_ADDR_W-1:0] waddr;
	logic [XLEN-1:0] wdata;

	modport reader (
		output rs1_addr, rs2_addr
	);
	modport storage (
		input rs1_addr, rs2_addr, we, waddr, wdata,
		output rs1_data, rs2_data
	);
	modport writer (
		input rs1_data, rs2_data,
		output we, waddr, wdata
	);
endinterface

// ==== src/rv_decode.sv ====
module rv_decode #(
	parameter int NUM_REGS = 32
) (
	input logic clk,
	input logic rst_n_i,
	input logic inst_valid_i,
	input logic [rv_exec_pkg::XLEN-1:0] inst_i,
	input logic [rv_exec_pkg::XLEN-1:0] pc_i,
	decode_if.producer dec,
	regfile_if.reader rf
);
	import rv_exec_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] rs1;
	logic [REG_ADDR_W-1:0] rs2;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	alu_op_e op_c;
	logic use_imm_c;
	logic [XLEN-1:0] imm_c;
	logic bad_enc;
	logic use_rd;
	logic use_rs1;
	logic use_rs2;
	logic err_c;

	function automatic logic out_of_range(input logic [REG_ADDR_W-1:0] a);
		return int'(a) >= NUM_REGS;   // rv32e has 16
	endfunction

	// ----------------------------------------
	// fields and immediates
	// ----------------------------------------
	assign opcode = opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign rd = inst_i[11:7];
	assign rs1 = inst_i[19:15];
	assign rs2 = inst_i[24:20];
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'h000};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		op_c = ALU_NONE;
		use_imm_c = 1'b0;
		imm_c = imm_i;
		bad_enc = 1'b0;
		use_rd = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				use_imm_c = 1'b1;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				case (funct3)
					F3_ADD_SUB: op_c = ALU_ADD;
					F3_SLT: op_c = ALU_SLT;
					F3_SLTU: op_c = ALU_SLTU;
					F3_XOR: op_c = ALU_XOR;
					F3_OR: op_c = ALU_OR;
					F3_AND: op_c = ALU_AND;
					F3_SLL: begin
						op_c = ALU_SLL;
						bad_enc = (funct7 != F7_BASE);
					end
					default: begin        // srli / srai
						op_c = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						bad_enc = (funct7 != F7_BASE) && (funct7 != F7_ALT);
					end
				endcase
			end
			OPC_OP: begin
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				if (funct7 == F7_BASE) begin
					case (funct3)
						F3_ADD_SUB: op_c = ALU_ADD;
						F3_SLL: op_c = ALU_SLL;
						F3_SLT: op_c = ALU_SLT;
						F3_SLTU: op_c = ALU_SLTU;
						F3_XOR: op_c = ALU_XOR;
						F3_SR: op_c = ALU_SRL;
						F3_OR: op_c = ALU_OR;
						default: op_c = ALU_AND;
					endcase
				end else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB) begin
					op_c = ALU_SUB;
				end else if (funct7 == F7_ALT && funct3 == F3_SR) begin
					op_c = ALU_SRA;
				end else begin
					bad_enc = 1'b1;       // mul/div group too
				end
			end
			OPC_LUI: begin
				op_c = ALU_PASS_B;
				use_imm_c = 1'b1;
				imm_c = imm_u;
				use_rd = 1'b1;
			end
			OPC_AUIPC: begin
				op_c = ALU_PASS_B;
				use_imm_c = 1'b1;
				imm_c = pc_i + imm_u;     // pc folded in here
				use_rd = 1'b1;
			end
			OPC_JAL: begin
				op_c = ALU_JAL;
				imm_c = imm_j;
				use_rd = 1'b1;
			end
			OPC_JALR: begin
				op_c = ALU_JALR;
				use_rd = 1'b1;
				use_rs1 = 1'b1;
				bad_enc = (funct3 != F3_JALR);
			end
			OPC_BRANCH: begin
				imm_c = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (funct3)
					F3_BEQ: op_c = ALU_BEQ;
					F3_BNE: op_c = ALU_BNE;
					F3_BLT: op_c = ALU_BLT;
					F3_BGE: op_c = ALU_BGE;
					F3_BLTU: op_c = ALU_BLTU;
					F3_BGEU: op_c = ALU_BGEU;
					default: bad_enc = 1'b1;
				endcase
			end
			OPC_MISC_MEM: bad_enc = (funct3 != F3_FENCE);  // fence only advances pc
			default: bad_enc = 1'b1;      // loads, stores, system
		endcase
	end

	assign err_c = bad_enc || (use_rd && out_of_range(rd)) ||
		(use_rs1 && out_of_range(rs1)) || (use_rs2 && out_of_range(rs2));

	// ----------------------------------------
	// decode register
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec.valid <= 1'b0;
			dec.alu_op <= ALU_NONE;
			dec.err <= 1'b0;
		end else begin
			dec.valid <= inst_valid_i;
			dec.alu_op <= (inst_valid_i && !err_c) ? op_c : ALU_NONE;
			dec.err <= inst_valid_i && err_c;
		end
	end

	always_ff @(posedge clk) begin
		dec.use_imm <= use_imm_c;
		dec.imm <= imm_c;
		dec.rd <= rd;
		dec.pc <= pc_i;
		rf.rs1_addr <= rs1;           // regfile read next cycle
		rf.rs2_addr <= rs2;
	end

	a_err_is_none: assert property (@(posedge clk) disable iff (!rst_n_i)
		dec.err |-> dec.alu_op == ALU_NONE)
		else $error("decode: err with alu_op %s", dec.alu_op.name());

endmodule

// ==== src/rv_regfile.sv ====
module rv_regfile #(
	parameter int NUM_REGS = 32
) (
	input logic clk,
	input logic rst_n_i,
	regfile_if.storage rf
);
	import rv_exec_pkg::*;

	localparam int IDX_W = $clog2(NUM_REGS);

	logic [XLEN-1:0] regs [NUM_REGS];

	// unimplemented numbers read as zero
	function automatic logic in_range(input logic [REG_ADDR_W-1:0] a);
		return int'(a) < NUM_REGS;
	endfunction

	// x0 and unimplemented numbers never take a write
	function automatic logic live_reg(input logic [REG_ADDR_W-1:0] a);
		return (a != '0) && in_range(a);
	endfunction

	assign rf.rs1_data = in_range(rf.rs1_addr) ? regs[rf.rs1_addr[IDX_W-1:0]] : '0;
	assign rf.rs2_data = in_range(rf.rs2_addr) ? regs[rf.rs2_addr[IDX_W-1:0]] : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.we && live_reg(rf.waddr)) begin
			regs[rf.waddr[IDX_W-1:0]] <= rf.wdata;  // x0 writes dropped
		end
	end

	a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
		(rf.rs1_addr == '0 |-> rf.rs1_data == '0) and
		(rf.rs2_addr == '0 |-> rf.rs2_data == '0))
		else $error("regfile: x0 read returned nonzero");

endmodule

// ==== src/rv_execute.sv ====
module rv_execute (
	input logic clk,
	input logic rst_n_i,
	decode_if.consumer dec,
	regfile_if.writer rf,
	output logic wb_valid_o,
	output logic wb_we_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [rv_exec_pkg::XLEN-1:0] wb_data_o,
	output logic [rv_exec_pkg::XLEN-1:0] pc_next_o,
	output logic inst_err_o
);
	import rv_exec_pkg::*;

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic [XLEN-1:0] alu_res;
	logic eq;
	logic lt_s;
	logic lt_u;
	logic taken;
	logic wr_en;
	logic [XLEN-1:0] pc_seq;
	logic [XLEN-1:0] pc_rel;
	logic [XLEN-1:0] jalr_sum;
	logic [XLEN-1:0] pc_next_c;

	// ----------------------------------------
	// operands and compare
	// ----------------------------------------
	assign op_a = rf.rs1_data;
	assign op_b = dec.use_imm ? dec.imm : rf.rs2_data;
	assign shamt = op_b[4:0];
	assign eq = (op_a == op_b);
	assign lt_s = ($signed(op_a) < $signed(op_b));
	assign lt_u = (op_a < op_b);

	always_comb begin
		case (dec.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_SLL: alu_res = op_a << shamt;
			ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SRL: alu_res = op_a >> shamt;
			ALU_SRA: alu_res = $signed(op_a) >>> shamt;
			ALU_OR: alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			ALU_JAL, ALU_JALR: alu_res = pc_seq;  // link address
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		case (dec.alu_op)
			ALU_BEQ: taken = eq;
			ALU_BNE: taken = !eq;
			ALU_BLT: taken = lt_s;
			ALU_BGE: taken = !lt_s;
			ALU_BLTU: taken = lt_u;
			ALU_BGEU: taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

	// ----------------------------------------
	// next pc
	// ----------------------------------------
	assign pc_seq = dec.pc + XLEN'(PC_STEP);
	assign pc_rel = dec.pc + dec.imm;       // branch and jal target
	assign jalr_sum = op_a + dec.imm;

	always_comb begin
		case (dec.alu_op)
			ALU_JAL: pc_next_c = pc_rel;
			ALU_JALR: pc_next_c = {jalr_sum[XLEN-1:1], 1'b0};
			default: pc_next_c = taken ? pc_rel : pc_seq;
		endcase
	end

	// errors already arrive as ALU_NONE
	assign wr_en = dec.valid && !(dec.alu_op inside {ALU_BEQ, ALU_BNE, ALU_BLT,
		ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_NONE});

	assign rf.we = wr_en;
	assign rf.waddr = dec.rd;
	assign rf.wdata = alu_res;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
			wb_we_o <= 1'b0;
			inst_err_o <= 1'b0;
		end else begin
			wb_valid_o <= dec.valid;
			wb_we_o <= wr_en;
			inst_err_o <= dec.valid && dec.err;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr_o <= dec.rd;
		wb_data_o <= alu_res;
		pc_next_o <= pc_next_c;
	end

	a_no_we_on_err: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(wb_we_o && inst_err_o))
		else $error("execute: writeback on illegal instruction");

endmodule

// ==== src/rv_exec_top.sv ====
module rv_exec_top #(
	parameter int NUM_REGS = 32
) (
	input logic clk,
	input logic rst_n_i,
	input logic inst_valid_i,
	input logic [rv_exec_pkg::XLEN-1:0] inst_i,
	input logic [rv_exec_pkg::XLEN-1:0] pc_i,
	output logic wb_valid_o,
	output logic wb_we_o,
	output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [rv_exec_pkg::XLEN-1:0] wb_data_o,
	output logic [rv_exec_pkg::XLEN-1:0] pc_next_o,
	output logic inst_err_o
);

	decode_if dec_bus ();
	regfile_if rf_bus ();

	// ----------------------------------------
	// decode, registers, execute
	// ----------------------------------------
	rv_decode #(.NUM_REGS(NUM_REGS)) rv_decode_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.dec(dec_bus.producer),
		.rf(rf_bus.reader)
	);

	rv_regfile #(.NUM_REGS(NUM_REGS)) rv_regfile_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.rf(rf_bus.storage)
	);

	rv_execute rv_execute_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.dec(dec_bus.consumer),
		.rf(rf_bus.writer),
		.wb_valid_o(wb_valid_o),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o),
		.pc_next_o(pc_next_o),
		.inst_err_o(inst_err_o)
	);

endmodule

// ==== tests/tb_rv_exec_top.sv ====
module tb_rv_exec_top;
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [31:0] regs_t [32];

	typedef struct packed {
		logic we;
		logic [4:0] addr;
		logic [31:0] data;
		logic [31:0] pc_next;
		logic err;
		logic [31:0] cyc;             // issue cycle
	} exp_t;

	localparam int N_READ = 32;
	localparam int N_SEED = 62;
	localparam int N_RAND = 200;
	localparam int N_JUMP = 34;
	localparam int N_BR = 28;
	localparam int N_ILL = 14;
	localparam int N_INSTR = 2 * N_READ + N_SEED + N_RAND + N_JUMP + N_BR + N_ILL;

	logic clk = 1'b0;
	logic rst_n_i;
	logic inst_valid_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic wb_valid_o;
	logic wb_we_o;
	logic [4:0] wb_addr_o;
	logic [31:0] wb_data_o;
	logic [31:0] pc_next_o;
	logic inst_err_o;

	regs_t model;                     // architectural state as issued
	exp_t exp_q[$];
	logic [31:0] cycle = '0;
	logic [31:0] pc_cur;
	logic [4:0] last_rd;
	int seed;
	int errors;

	rv_exec_top #(.NUM_REGS(32)) rv_exec_top_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.inst_valid_i(inst_valid_i),
		.inst_i(inst_i),
		.pc_i(pc_i),
		.wb_valid_o(wb_valid_o),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o),
		.pc_next_o(pc_next_o),
		.inst_err_o(inst_err_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 32'd1;

	// ----------------------------------------
	// encoders and reference model
	// ----------------------------------------
	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic exp_t predict(input logic [31:0] inst, input logic [31:0] pc,
		input regs_t rm);
		logic [2:0] f3;
		logic [6:0] f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] x;
		logic take;
		exp_t e;
		f3 = inst[14:12];
		f7 = inst[31:25];
		a = rm[inst[19:15]];
		b = rm[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		x = '0;
		take = 1'b0;
		e = '0;
		e.addr = inst[11:7];
		e.pc_next = pc + 32'd4;
		case (inst[6:0])
			7'h13: begin               // op-imm, shamt sits in imm_i[4:0]
				e.we = 1'b1;
				if (f3 == 3'd1) e.err = (f7 != 7'h00);
				if (f3 == 3'd5) e.err = (f7 != 7'h00) && (f7 != 7'h20);
				x = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
			end
			7'h33: begin
				e.we = 1'b1;
				e.err = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				x = alu_ref(f3, f7[5], a, b);
			end
			7'h37: begin
				e.we = 1'b1;
				x = {inst[31:12], 12'h000};
			end
			7'h17: begin
				e.we = 1'b1;
				x = pc + {inst[31:12], 12'h000};
			end
			7'h6f: begin
				e.we = 1'b1;
				x = pc + 32'd4;
				e.pc_next = pc + imm_j;
			end
			7'h67: begin
				e.we = 1'b1;
				e.err = (f3 != 3'd0);
				x = pc + 32'd4;
				e.pc_next = (a + imm_i) & ~32'd1;    // bit 0 cleared
			end
			7'h63: begin
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = ($signed(a) < $signed(b));
					3'd5: take = !($signed(a) < $signed(b));
					3'd6: take = (a < b);
					3'd7: take = !(a < b);
					default: e.err = 1'b1;
				endcase
				if (take) e.pc_next = pc + imm_b;
			end
			7'h0f: e.err = (f3 != 3'd0);   // fence
			default: e.err = 1'b1;
		endcase
		if (e.err) begin
			e.we = 1'b0;
			e.pc_next = pc + 32'd4;
		end
		e.data = x;
		return e;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
			errors++;
		end
	endtask

	// ----------------------------------------
	// stimulus tasks
	// ----------------------------------------
	task automatic issue(input logic [31:0] inst);
		exp_t e;
		@(negedge clk);
		e = predict(inst, pc_cur, model);
		e.cyc = cycle;
		exp_q.push_back(e);
		if (e.we && e.addr != 5'd0) model[e.addr] = e.data;
		inst_valid_i = 1'b1;
		inst_i = inst;
		pc_i = pc_cur;
		pc_cur = pc_cur + 32'd4;
		last_rd = inst[11:7];
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			inst_valid_i = 1'b0;
		end
	endtask

	// addi xi, xi, 0 shows every register on wb_data_o
	task automatic read_all();
		for (int i = 0; i < 32; i++) begin
			issue(enc_i(7'h13, 3'd0, 5'(i), 5'(i), 12'd0));
		end
	endtask

	task automatic random_alu();
		logic [31:0] r;
		logic [2:0] f3;
		logic [4:0] rs1;
		logic [6:0] f7;
		logic [11:0] imm;
		r = $random(seed);
		f3 = r[2:0];
		rs1 = r[20] ? last_rd : r[14:10];     // dependent pair
		f7 = (r[4] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
		if (r[3]) begin
			issue(enc_r(f7, f3, r[9:5], rs1, r[19:15]));
		end else begin
			imm = r[31:20];
			if (f3 == 3'd1 || f3 == 3'd5) imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
			issue(enc_i(7'h13, f3, r[9:5], rs1, imm));
		end
	endtask

	task automatic jump_tests();
		logic [31:0] r;
		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			pc_cur = {r[31:2], 2'b00};
			r = $random(seed);
			issue({r[31:12], r[11:7], 7'h37});    // lui
			r = $random(seed);
			issue({r[31:12], r[11:7], 7'h17});    // auipc
			r = $random(seed);
			issue(enc_j(r[4:0], {r[31:12], 1'b0}));
			r = $random(seed);
			issue(enc_i(7'h67, 3'd0, r[4:0], r[9:5], r[31:20]));
		end
		issue(enc_i(7'h13, 3'd0, 5'd7, 5'd0, 12'd1));
		issue(enc_i(7'h67, 3'd0, 5'd8, 5'd7, 12'h010));  // odd sum
	endtask

	task automatic branch_tests();
		logic [31:0] r;
		logic [4:0] ra;
		logic [4:0] rb;
		issue(enc_i(7'h13, 3'd0, 5'd1, 5'd0, 12'd5));
		issue(enc_i(7'h13, 3'd0, 5'd2, 5'd0, 12'd5));
		issue(enc_i(7'h13, 3'd0, 5'd3, 5'd0, 12'hffd));  // -3, large unsigned
		issue(enc_i(7'h13, 3'd0, 5'd4, 5'd0, 12'd7));
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 == 2 || f3 == 3) continue;
			for (int p = 0; p < 4; p++) begin
				ra = (p == 0) ? 5'd1 : (p == 1) ? 5'd3 : (p == 2) ? 5'd4 : 5'd1;
				rb = (p == 0) ? 5'd2 : (p == 1) ? 5'd4 : (p == 2) ? 5'd3 : 5'd4;
				r = $random(seed);
				issue(enc_b(3'(f3), ra, rb, {r[12:1], 1'b0}));
			end
		end
	endtask

	task automatic illegal_tests();
		issue(enc_i(7'h03, 3'd2, 5'd9, 5'd1, 12'd0));     // lw
		issue({7'd0, 5'd2, 5'd1, 3'd2, 5'd0, 7'h23});       // sw
		issue(32'h0000_0073);                               // ecall
		issue(32'h3020_0073);                               // mret
		issue(enc_r(7'h01, 3'd0, 5'd10, 5'd1, 5'd2));       // mul
		issue(enc_r(7'h20, 3'd1, 5'd11, 5'd1, 5'd2));
		issue(enc_i(7'h13, 3'd1, 5'd12, 5'd1, 12'h405));   // slli, bad funct7
		issue(enc_b(3'd2, 5'd1, 5'd2, 13'd8));
		issue(enc_i(7'h67, 3'd1, 5'd13, 5'd1, 12'd0));
		issue(enc_i(7'h0f, 3'd1, 5'd0, 5'd0, 12'd0));      // fence.i
		issue(32'hffff_ffff);
		issue(enc_i(7'h0f, 3'd0, 5'd0, 5'd0, 12'h0ff));    // plain fence
		issue(enc_i(7'h13, 3'd0, 5'd0, 5'd0, 12'h123));    // write to x0
		issue(enc_i(7'h13, 3'd0, 5'd14, 5'd0, 12'd0));
	endtask

	// ----------------------------------------
	// compare and watchdog
	// ----------------------------------------
	always @(negedge clk) begin
		exp_t e;
		if (rst_n_i && wb_valid_o) begin
			if (exp_q.size() == 0) begin
				$display("ERROR: writeback output appeared with no instruction pending");
				errors++;
			end else begin
				e = exp_q.pop_front();
				check("latency", e.cyc + 32'd2, cycle);
				check("wb_we_o", 32'(e.we), 32'(wb_we_o));
				check("inst_err_o", 32'(e.err), 32'(inst_err_o));
				check("pc_next_o", e.pc_next, pc_next_o);
				if (e.we) begin
					check("wb_addr_o", 32'(e.addr), 32'(wb_addr_o));
					check("wb_data_o", e.data, wb_data_o);
				end
			end
		end else if (exp_q.size() != 0 && cycle >= exp_q[0].cyc + 32'd2) begin
			$display("ERROR: an expected writeback did not arrive in time");
			errors++;
			void'(exp_q.pop_front());
		end
	end

	initial begin
		#((N_INSTR + 20) * 8 * 2);
		$display("ERROR: timeout, the run did not finish in the expected time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed = 66043;
		errors = 0;
		rst_n_i = 1'b0;
		inst_valid_i = 1'b0;
		inst_i = '0;
		pc_i = '0;
		pc_cur = 32'h0000_1000;
		last_rd = '0;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		check("wb_valid_o", 32'd0, 32'(wb_valid_o));
		check("wb_we_o", 32'd0, 32'(wb_we_o));
		check("inst_err_o", 32'd0, 32'(inst_err_o));

		read_all();                       // all zero after reset
		for (int i = 1; i < 32; i++) begin
			logic [31:0] r;
			r = $random(seed);
			issue({r[31:12], 5'(i), 7'h37});
			issue(enc_i(7'h13, 3'd0, 5'(i), 5'(i), r[11:0]));
		end
		repeat (N_RAND) random_alu();
		jump_tests();
		branch_tests();
		illegal_tests();
		read_all();
		idle(4);

		if (exp_q.size() != 0) begin
			$display("ERROR: %0d expected writebacks never arrived", exp_q.size());
			errors += exp_q.size();
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== rv_exec_top.f ====
src/rv_exec_pkg.sv
src/rv_exec_ifs.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_exec_top.sv
tests/tb_rv_exec_top.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the execute path testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_rv_exec_top -f rv_exec_top.f -o sim_rv_exec
./obj_dir/sim_rv_exec 2>&1 | tee sim.log
if grep -q "TB FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"
